//--- tb.f
src/tetris_pkg.sv
src/vga_timing.sv
src/piece_control.sv
src/playfield.sv
src/grid_layer.sv
src/score_layer.sv
src/color_arbiter.sv
src/tetris_top.sv
bench/tetris_properties.sv
bench/tetris_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tetris_tb -f tb.f -o tetris_sim &&
./obj_dir/tetris_sim +verilator+error+limit+10 | tee /dev/stderr \
  | grep "All tests passed" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- bench/tetris_tb.sv
module tetris_tb import tetris_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic       hz100;
  logic       arst_n;
  logic       btn_left;
  logic       btn_right;
  logic       new_game;
  logic       red, green, blue;
  logic       hsync_n, vsync_n;
  logic [7:0] score;
  logic       game_over;
  int         seed_draw;

  tetris_top UUT (
    .hz100     (hz100),
    .arst_n    (arst_n),
    .btn_left  (btn_left),
    .btn_right (btn_right),
    .new_game  (new_game),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .score     (score),
    .game_over (game_over)
  );

  // checker sees ports plus raster, piece and land inside the top
  bind tetris_top tetris_properties u_props (
    .hz100     (hz100),
    .arst_n    (arst_n),
    .btn_left  (btn_left),
    .btn_right (btn_right),
    .new_game  (new_game),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .score     (score),
    .game_over (game_over),
    .pix       (pix),
    .piece     (piece),
    .land      (land)
  );

  // 40 ns period
  always #20 hz100 = ~hz100;

  task automatic abort_timeout(input string what);
    $display("Some tests failed");
    $fatal(1, "timed out waiting for %s", what);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    $display("Some tests failed");
    $fatal(1, "check %s did not hold", name);
  endtask

  // first failed property stops the run
  always @(posedge hz100) begin
    if (UUT.u_props.fail_count != 0) begin
      report_mismatch(UUT.u_props.fail_name, UUT.u_props.fail_exp, UUT.u_props.fail_act);
    end
  end

  task automatic wait_piece(input logic level, input int limit);
    int n;
    n = 0;
    while (UUT.u_piece_control.piece.valid !== level) begin
      if (n == limit) begin
        abort_timeout(level ? "a piece to spawn" : "a piece to land");
      end else begin
        @(posedge hz100);
        n++;
      end
    end
  endtask

  task automatic wait_game_over(input int limit);
    int n;
    n = 0;
    while (game_over !== 1'b1) begin
      if (n == limit) begin
        abort_timeout("game over");
      end else begin
        @(posedge hz100);
        n++;
      end
    end
  endtask

  // counts falling edges of vsync, about one frame each
  task automatic wait_vsync_falls(input int count);
    int   n;
    int   seen;
    logic prev;
    n    = 0;
    seen = 0;
    prev = vsync_n;
    while (seen < count) begin
      if (n == count * H_TOTAL * V_TOTAL + H_TOTAL) begin
        abort_timeout("vertical sync");
      end else begin
        @(posedge hz100);
        if (prev && !vsync_n) begin
          seen++;
        end
        prev = vsync_n;
        n++;
      end
    end
  endtask

  // one clock high after a random gap, far from the next fall step
  task automatic press(input logic go_left);
    int gap;
    gap = 1 + int'($urandom % 8);
    repeat (gap) @(posedge hz100);
    if (go_left) begin
      btn_left <= 1'b1;
    end else begin
      btn_right <= 1'b1;
    end
    @(posedge hz100);
    btn_left  <= 1'b0;
    btn_right <= 1'b0;
  endtask

  task automatic place_piece(input int target);
    int steps;
    wait_piece(1'b1, 3 * TICK_DIV);
    steps = target - SPAWN_COL;
    while (steps < 0) begin
      press(1'b1);
      steps++;
    end
    while (steps > 0) begin
      press(1'b0);
      steps--;
    end
    wait_piece(1'b0, (GRID_ROWS + 2) * TICK_DIV);
  endtask

  initial begin
    seed_draw = $urandom(26);
    hz100     = 1'b0;
    arst_n    = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    new_game  = 1'b0;
    repeat (5) @(posedge hz100);
    arst_n <= 1'b1;

    // no buttons, column 4 fills up
    wait_game_over(400 * TICK_DIV);
    assert (score == 8'd0) else report_mismatch("stack_score", 0, int'(score));
    // several game steps go by while game_over has to hold
    repeat (3 * TICK_DIV) @(posedge hz100);

    @(posedge hz100);
    new_game <= 1'b1;
    repeat (2) @(posedge hz100);
    new_game <= 1'b0;
    @(posedge hz100);
    assert (!game_over) else report_mismatch("restart_game_over", 0, int'(game_over));
    assert (score == 8'd0) else report_mismatch("restart_score", 0, int'(score));

    // bottom two rows filled edge to edge
    for (int i = 0; i < 5; i++) begin
      place_piece(2 * i);
    end
    // next spawn comes well after the collapse
    wait_piece(1'b1, 3 * TICK_DIV);
    assert (score == 8'd2) else report_mismatch("two_rows_score", 2, int'(score));

    // two frames so the raster checks see the new score
    wait_vsync_falls(2);
    if (UUT.u_props.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "a property failed in the last clock of the run");
    end
  end

endmodule

//--- bench/tetris_properties.sv
module tetris_properties import tetris_pkg::*; (
  input logic       hz100,
  input logic       arst_n,
  input logic       btn_left,
  input logic       btn_right,
  input logic       new_game,
  input logic       red,
  input logic       green,
  input logic       blue,
  input logic       hsync_n,
  input logic       vsync_n,
  input logic [7:0] score,
  input logic       game_over,
  input pixel_t     pix,
  input piece_t     piece,
  input logic       land
);

  timeunit 1ns;
  timeprecision 1ps;

  color_t     rgb;
  logic       hs_q, vs_q, h_seen, v_seen, h_fall, v_fall;
  int         h_low, h_gap, v_low, v_gap;
  int         px, py, sq_slot, sq_off;
  logic       on_ring, in_sq, act_q, ring_q, sq_q;
  color_t     sq_color, sq_color_q;
  logic       ng_q, ng_edge, ng_edge_q, go_q, btn_seen;
  logic [7:0] score_q;
  // last failure, read by the testbench
  int         fail_count = 0;
  string      fail_name;
  int         fail_exp;
  int         fail_act;

  assign rgb     = {red, green, blue};
  assign h_fall  = hs_q & ~hsync_n;
  assign v_fall  = vs_q & ~vsync_n;
  assign ng_edge = new_game & ~ng_q;

  task automatic record_failure(input string name, input int expected, input int actual);
    fail_count++;
    fail_name = name;
    fail_exp  = expected;
    fail_act  = actual;
    $error("%s: expected %0d, actual %0d", name, expected, actual);
  endtask

  // expected pixel class from screen geometry
  always_comb begin
    px      = int'(pix.x);
    py      = int'(pix.y);
    // outer box minus the playfield itself
    on_ring = px >= GRID_X0 - CELL_PX && px < GRID_X0 + (GRID_COLS + 1) * CELL_PX &&
              py >= GRID_Y0 - CELL_PX && py < GRID_Y0 + (GRID_ROWS + 1) * CELL_PX &&
              !(px >= GRID_X0 && px < GRID_X0 + GRID_COLS * CELL_PX &&
                py >= GRID_Y0 && py < GRID_Y0 + GRID_ROWS * CELL_PX);
    in_sq    = 1'b0;
    sq_color = BLACK;
    // slot counted from the left edge of the readout
    sq_slot  = (px - SCORE_X0) / SCORE_PITCH;
    sq_off   = (px - SCORE_X0) % SCORE_PITCH;
    // slot 0 is the leftmost square and shows bit 7
    if (py >= SCORE_Y0 && py < SCORE_Y0 + SCORE_SQ && px >= SCORE_X0 &&
        sq_slot < 8 && sq_off < SCORE_SQ) begin
      in_sq    = 1'b1;
      sq_color = score[7 - sq_slot] ? GREEN : BLUE;
    end
  end

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      hs_q       <= 1'b1;
      vs_q       <= 1'b1;
      h_seen     <= 1'b0;
      v_seen     <= 1'b0;
      h_low      <= 0;
      h_gap      <= 0;
      v_low      <= 0;
      v_gap      <= 0;
      act_q      <= 1'b0;
      ring_q     <= 1'b0;
      sq_q       <= 1'b0;
      sq_color_q <= BLACK;
      ng_q       <= 1'b0;
      ng_edge_q  <= 1'b0;
      go_q       <= 1'b0;
      btn_seen   <= 1'b0;
      score_q    <= '0;
    end else begin
      hs_q   <= hsync_n;
      vs_q   <= vsync_n;
      // low run lengths and edge to edge spacing, in clocks
      h_low  <= hsync_n ? 0 : h_low + 1;
      v_low  <= vsync_n ? 0 : v_low + 1;
      h_gap  <= h_fall ? 1 : h_gap + 1;
      v_gap  <= v_fall ? 1 : v_gap + 1;
      h_seen <= h_seen | h_fall;
      v_seen <= v_seen | v_fall;
      // pixel one clock back, lines up with the registered rgb
      act_q      <= pix.active;
      ring_q     <= on_ring;
      sq_q       <= in_sq;
      sq_color_q <= sq_color;
      ng_q       <= new_game;
      ng_edge_q  <= ng_edge;
      go_q       <= game_over;
      btn_seen   <= btn_seen | btn_left | btn_right;
      score_q    <= score;
    end
  end

  a_hsync_width: assert property (@(posedge hz100) disable iff (!arst_n)
    (!hs_q && hsync_n) |-> h_low == H_SYNC)
    else record_failure("hsync_width", H_SYNC, $sampled(h_low));
  a_hsync_period: assert property (@(posedge hz100) disable iff (!arst_n)
    (h_fall && h_seen) |-> h_gap == H_TOTAL)
    else record_failure("hsync_period", H_TOTAL, $sampled(h_gap));
  // vertical pulse measured in clocks, lines times 800
  a_vsync_width: assert property (@(posedge hz100) disable iff (!arst_n)
    (!vs_q && vsync_n) |-> v_low == V_SYNC * H_TOTAL)
    else record_failure("vsync_width", V_SYNC * H_TOTAL, $sampled(v_low));
  a_vsync_period: assert property (@(posedge hz100) disable iff (!arst_n)
    (v_fall && v_seen) |-> v_gap == V_TOTAL * H_TOTAL)
    else record_failure("vsync_period", V_TOTAL * H_TOTAL, $sampled(v_gap));
  a_blank: assert property (@(posedge hz100) disable iff (!arst_n)
    !act_q |-> rgb == BLACK)
    else record_failure("blanking", BLACK, $sampled(rgb));
  a_border: assert property (@(posedge hz100) disable iff (!arst_n)
    ring_q |-> rgb == WHITE)
    else record_failure("border", WHITE, $sampled(rgb));
  a_score_square: assert property (@(posedge hz100) disable iff (!arst_n)
    sq_q |-> rgb == sq_color_q)
    else record_failure("score_square", $sampled(sq_color_q), $sampled(rgb));
  // untouched pieces land where they spawned
  a_spawn_column: assert property (@(posedge hz100) disable iff (!arst_n)
    (land && !btn_seen) |-> piece.col == 4'(SPAWN_COL))
    else record_failure("spawn_column", SPAWN_COL, $sampled(piece.col));
  a_over_holds: assert property (@(posedge hz100) disable iff (!arst_n)
    (go_q && !ng_edge_q) |-> game_over)
    else record_failure("game_over_hold", 1, $sampled(game_over));
  a_new_game: assert property (@(posedge hz100) disable iff (!arst_n)
    ng_edge_q |-> !game_over && score == 8'd0)
    else record_failure("new_game_clear", 0, $sampled({game_over, score}));
  a_score_rises: assert property (@(posedge hz100) disable iff (!arst_n)
    !ng_edge_q |-> score >= score_q)
    else record_failure("score_monotonic", $sampled(score_q), $sampled(score));

endmodule

//--- src/tetris_top.sv
module tetris_top import tetris_pkg::*; (
  input  logic       hz100,
  input  logic       arst_n,
  input  logic       btn_left,
  input  logic       btn_right,
  input  logic       new_game,
  output logic       red,
  output logic       green,
  output logic       blue,
  output logic       hsync_n,
  output logic       vsync_n,
  output logic [7:0] score,
  output logic       game_over
);

  pixel_t pix;
  piece_t piece;
  cells_t cells;
  logic   land;
  logic   clear_field;
  logic   row_cleared;
  logic   grid_req, score_req;
  color_t grid_color, score_color;

  // raster position, one pixel per clock
  vga_timing u_vga_timing (
    .hz100  (hz100),
    .arst_n (arst_n),
    .pix    (pix)
  );

  // game FSM and score
  piece_control u_piece_control (
    .hz100       (hz100),
    .arst_n      (arst_n),
    .btn_left    (btn_left),
    .btn_right   (btn_right),
    .new_game    (new_game),
    .cells       (cells),
    .row_cleared (row_cleared),
    .piece       (piece),
    .land        (land),
    .clear_field (clear_field),
    .score       (score),
    .game_over   (game_over)
  );

  // stored cells and row collapse
  playfield u_playfield (
    .hz100       (hz100),
    .arst_n      (arst_n),
    .piece       (piece),
    .land        (land),
    .clear_field (clear_field),
    .cells       (cells),
    .row_cleared (row_cleared)
  );

  grid_layer u_grid_layer (
    .pix   (pix),
    .piece (piece),
    .cells (cells),
    .req   (grid_req),
    .color (grid_color)
  );

  score_layer u_score_layer (
    .pix   (pix),
    .score (score),
    .req   (score_req),
    .color (score_color)
  );

  // registered pixel output
  color_arbiter u_color_arbiter (
    .hz100       (hz100),
    .arst_n      (arst_n),
    .pix         (pix),
    .score_req   (score_req),
    .score_color (score_color),
    .grid_req    (grid_req),
    .grid_color  (grid_color),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n)
  );

endmodule

//--- src/color_arbiter.sv
module color_arbiter import tetris_pkg::*; (
  input  logic   hz100,
  input  logic   arst_n,
  input  pixel_t pix,
  input  logic   score_req,
  input  color_t score_color,
  input  logic   grid_req,
  input  color_t grid_color,
  output logic   red,
  output logic   green,
  output logic   blue,
  output logic   hsync_n,
  output logic   vsync_n
);

  color_t pick;
  color_t color_q;

  // score first, then grid, blank outside the active area
  always_comb begin
    if (!pix.active) begin
      pick = BLACK;
    end else if (score_req) begin
      pick = score_color;
    end else if (grid_req) begin
      pick = grid_color;
    end else begin
      pick = BLACK;
    end
  end

  // syncs take the same one clock as the colour
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      color_q <= BLACK;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
    end else begin
      color_q <= pick;
      hsync_n <= pix.hsync_n;
      vsync_n <= pix.vsync_n;
    end
  end

  assign {red, green, blue} = color_q;

endmodule

//--- src/score_layer.sv
module score_layer import tetris_pkg::*; (
  input  pixel_t     pix,
  input  logic [7:0] score,
  output logic       req,
  output color_t     color
);

  logic in_row;
  int   left;

  always_comb begin
    // all squares share one band of lines
    in_row = (pix.y >= 10'(SCORE_Y0)) && (pix.y < 10'(SCORE_Y0 + SCORE_SQ));
    req    = 1'b0;
    color  = BLACK;
    left   = 0;
    for (int i = 0; i < 8; i++) begin
      // bit 7 leftmost, bit 0 rightmost
      left = SCORE_X0 + (7 - i) * SCORE_PITCH;
      if (in_row && int'(pix.x) >= left && int'(pix.x) < left + SCORE_SQ) begin
        req = 1'b1;
        // set bits green, clear bits blue
        if (score[i]) begin
          color = GREEN;
        end else begin
          color = BLUE;
        end
      end
    end
  end

endmodule

//--- src/grid_layer.sv
module grid_layer import tetris_pkg::*; (
  input  pixel_t pix,
  input  piece_t piece,
  input  cells_t cells,
  output logic   req,
  output color_t color
);

  logic [9:0] dx, dy;
  logic [5:0] bx, by;
  logic       in_box, on_ring;
  logic [4:0] cell_row;
  logic [3:0] cell_col;
  logic       on_piece;
  color_t     stored;

  always_comb begin
    // offset from the outer corner of the border ring
    dx     = pix.x - 10'(RING_X0);
    dy     = pix.y - 10'(RING_Y0);
    bx     = 6'(dx >> CELL_SHIFT);
    by     = 6'(dy >> CELL_SHIFT);
    in_box = (pix.x >= 10'(RING_X0)) && (pix.x < 10'(RING_X0 + RING_COLS * CELL_PX)) &&
             (pix.y >= 10'(RING_Y0)) && (pix.y < 10'(RING_Y0 + RING_ROWS * CELL_PX));
    on_ring = in_box && (bx == 6'd0 || bx == 6'(RING_COLS - 1) ||
                         by == 6'd0 || by == 6'(RING_ROWS - 1));
    // ring index 1 is playfield index 0
    cell_col = 4'(bx - 6'd1);
    cell_row = 5'(by - 6'd1);
    on_piece = piece.valid &&
               (cell_row == piece.row || cell_row == piece.row + 5'd1) &&
               (cell_col == piece.col || cell_col == piece.col + 4'd1);
    stored = BLACK;
    req    = 1'b0;
    color  = BLACK;
    if (on_ring) begin
      req   = 1'b1;
      color = WHITE;
    end else if (in_box) begin
      stored = cells[int'(cell_row) * GRID_COLS + int'(cell_col)];
      // falling piece drawn over the stack
      if (on_piece) begin
        req   = 1'b1;
        color = piece.color;
      end else if (stored != BLACK) begin
        req   = 1'b1;
        color = stored;
      end
    end
  end

endmodule

//--- src/playfield.sv
module playfield import tetris_pkg::*; (
  input  logic   hz100,
  input  logic   arst_n,
  input  piece_t piece,
  input  logic   land,
  input  logic   clear_field,
  output cells_t cells,
  output logic   row_cleared
);

  logic [GRID_ROWS-1:0] row_full;
  logic                 any_full;
  int                   full_row;
  int                   base;

  // lowest full row wins, loop keeps the last hit
  always_comb begin
    any_full = 1'b0;
    full_row = 0;
    for (int r = 0; r < GRID_ROWS; r++) begin
      row_full[r] = 1'b1;
      for (int c = 0; c < GRID_COLS; c++) begin
        if (cells[r * GRID_COLS + c] == BLACK) begin
          row_full[r] = 1'b0;
        end
      end
      if (row_full[r]) begin
        any_full = 1'b1;
        full_row = r;
      end
    end
  end

  // landing cell of the top-left corner
  assign base = int'(piece.row) * GRID_COLS + int'(piece.col);

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      cells       <= '0;
      row_cleared <= 1'b0;
    end else begin
      row_cleared <= 1'b0;
      if (clear_field) begin
        cells <= '0;
      end else if (land) begin
        cells[base]                 <= piece.color;
        cells[base + 1]             <= piece.color;
        cells[base + GRID_COLS]     <= piece.color;
        cells[base + GRID_COLS + 1] <= piece.color;
      end else if (any_full) begin
        row_cleared <= 1'b1;
        // top row empties, rows down to the full one move down by one
        for (int c = 0; c < GRID_COLS; c++) begin
          cells[c] <= BLACK;
        end
        for (int r = 1; r < GRID_ROWS; r++) begin
          if (r <= full_row) begin
            for (int c = 0; c < GRID_COLS; c++) begin
              cells[r * GRID_COLS + c] <= cells[(r - 1) * GRID_COLS + c];
            end
          end
        end
      end
    end
  end

endmodule

//--- src/piece_control.sv
module piece_control import tetris_pkg::*; (
  input  logic       hz100,
  input  logic       arst_n,
  input  logic       btn_left,
  input  logic       btn_right,
  input  logic       new_game,
  input  cells_t     cells,
  input  logic       row_cleared,
  output piece_t     piece,
  output logic       land,
  output logic       clear_field,
  output logic [7:0] score,
  output logic       game_over
);

  typedef enum logic [1:0] {
    S_SPAWN,
    S_FALL,
    S_SETTLE,
    S_OVER
  } state_t;

  state_t            state;
  color_t            next_color;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick;
  logic              left_q, right_q, new_game_q;
  logic              left_edge, right_edge, new_game_edge;
  logic              below_blocked, left_blocked, right_blocked, spawn_blocked;

  // walls and the floor count as occupied
  function automatic logic occupied(cells_t f, int r, int c);
    if (r < 0 || r >= GRID_ROWS || c < 0 || c >= GRID_COLS) begin
      return 1'b1;
    end
    return f[r * GRID_COLS + c] != BLACK;
  endfunction

  // red green blue yellow magenta cyan, then wrap
  function automatic color_t advance(color_t c);
    case (c)
      RED:     return GREEN;
      GREEN:   return BLUE;
      BLUE:    return YELLOW;
      YELLOW:  return MAGENTA;
      MAGENTA: return CYAN;
      default: return RED;
    endcase
  endfunction

  assign tick          = (tick_cnt == TICK_W'(TICK_DIV - 1));
  assign left_edge     = btn_left & ~left_q;
  assign right_edge    = btn_right & ~right_q;
  assign new_game_edge = new_game & ~new_game_q;

  always_comb begin
    below_blocked = occupied(cells, int'(piece.row) + 2, int'(piece.col)) ||
                    occupied(cells, int'(piece.row) + 2, int'(piece.col) + 1);
    left_blocked  = occupied(cells, int'(piece.row), int'(piece.col) - 1) ||
                    occupied(cells, int'(piece.row) + 1, int'(piece.col) - 1);
    right_blocked = occupied(cells, int'(piece.row), int'(piece.col) + 2) ||
                    occupied(cells, int'(piece.row) + 1, int'(piece.col) + 2);
    spawn_blocked = occupied(cells, 0, SPAWN_COL) || occupied(cells, 0, SPAWN_COL + 1) ||
                    occupied(cells, 1, SPAWN_COL) || occupied(cells, 1, SPAWN_COL + 1);
  end

  // step divider, restarted by new_game so the cleared field settles first
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt   <= '0;
      left_q     <= 1'b0;
      right_q    <= 1'b0;
      new_game_q <= 1'b0;
    end else begin
      left_q     <= btn_left;
      right_q    <= btn_right;
      new_game_q <= new_game;
      if (tick || new_game_edge) begin
        tick_cnt <= '0;
      end else begin
        tick_cnt <= tick_cnt + TICK_W'(1);
      end
    end
  end

  // cleared rows, saturating
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      score <= '0;
    end else if (new_game_edge) begin
      score <= '0;
    end else if (row_cleared && score != 8'hff) begin
      score <= score + 8'd1;
    end
  end

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      state       <= S_SPAWN;
      piece       <= '0;
      next_color  <= RED;
      land        <= 1'b0;
      clear_field <= 1'b0;
      game_over   <= 1'b0;
    end else begin
      land        <= 1'b0;
      clear_field <= 1'b0;
      if (new_game_edge) begin
        clear_field <= 1'b1;
        game_over   <= 1'b0;
        piece.valid <= 1'b0;
        state       <= S_SPAWN;
      end else begin
        case (state)
          S_SPAWN: if (tick) begin
            if (spawn_blocked) begin
              game_over <= 1'b1;
              state     <= S_OVER;
            end else begin
              piece      <= '{row: 5'd0, col: 4'(SPAWN_COL), color: next_color, valid: 1'b1};
              next_color <= advance(next_color);
              state      <= S_FALL;
            end
          end
          // tick wins over a press in the same clock
          S_FALL: if (tick) begin
            if (below_blocked) begin
              land  <= 1'b1;
              state <= S_SETTLE;
            end else begin
              piece.row <= piece.row + 5'd1;
            end
          end else if (left_edge && !left_blocked) begin
            piece.col <= piece.col - 4'd1;
          end else if (right_edge && !right_blocked) begin
            piece.col <= piece.col + 4'd1;
          end
          // piece stays visible for the land pulse only
          S_SETTLE: begin
            if (land) begin
              piece.valid <= 1'b0;
            end
            if (tick) begin
              state <= S_SPAWN;
            end
          end
          default: state <= S_OVER;
        endcase
      end
    end
  end

endmodule

//--- src/vga_timing.sv
module vga_timing import tetris_pkg::*; (
  input  logic   hz100,
  input  logic   arst_n,
  output pixel_t pix
);

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;

  // free running 800 x 525 scan
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == 10'(H_TOTAL - 1)) begin
      h_cnt <= '0;
      // line wraps at the end of the frame
      if (v_cnt == 10'(V_TOTAL - 1)) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 10'd1;
      end
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  always_comb begin
    pix.x      = h_cnt;
    pix.y      = v_cnt;
    pix.active = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
    // sync pulses sit after the front porch, active low
    pix.hsync_n = !((h_cnt >= 10'(H_ACTIVE + H_FRONT)) &&
                    (h_cnt <  10'(H_ACTIVE + H_FRONT + H_SYNC)));
    pix.vsync_n = !((v_cnt >= 10'(V_ACTIVE + V_FRONT)) &&
                    (v_cnt <  10'(V_ACTIVE + V_FRONT + V_SYNC)));
  end

endmodule

//--- src/tetris_pkg.sv
package tetris_pkg;

  // one bit per gun, red green blue
  typedef logic [2:0] color_t;

  localparam color_t BLACK   = 3'b000;
  localparam color_t RED     = 3'b100;
  localparam color_t GREEN   = 3'b010;
  localparam color_t BLUE    = 3'b001;
  localparam color_t YELLOW  = 3'b110;
  localparam color_t MAGENTA = 3'b101;
  localparam color_t CYAN    = 3'b011;
  localparam color_t WHITE   = 3'b111;

  // playfield geometry, row 0 at the top
  localparam int GRID_COLS  = 10;
  localparam int GRID_ROWS  = 20;
  localparam int CELL_PX    = 16;
  localparam int CELL_SHIFT = $clog2(CELL_PX);
  localparam int GRID_X0    = 240;
  localparam int GRID_Y0    = 80;
  // border ring is one cell wide
  localparam int RING_X0    = GRID_X0 - CELL_PX;
  localparam int RING_Y0    = GRID_Y0 - CELL_PX;
  localparam int RING_COLS  = GRID_COLS + 2;
  localparam int RING_ROWS  = GRID_ROWS + 2;

  // score readout, bit 7 leftmost
  localparam int SCORE_X0    = 40;
  localparam int SCORE_Y0    = 40;
  localparam int SCORE_SQ    = 16;
  localparam int SCORE_PITCH = 24;

  // 640x480 raster
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // game step rate and spawn point
  localparam int TICK_DIV  = 100;
  localparam int TICK_W    = $clog2(TICK_DIV);
  localparam int SPAWN_COL = 4;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic       active;
    logic       hsync_n;
    logic       vsync_n;
  } pixel_t;

  // top-left cell of the 2x2 piece
  typedef struct packed {
    logic [4:0] row;
    logic [3:0] col;
    color_t     color;
    logic       valid;
  } piece_t;

  // index is row * GRID_COLS + col, BLACK when empty
  typedef color_t [GRID_ROWS*GRID_COLS-1:0] cells_t;

endpackage
